/* compile.f */
src/cpuPkg.sv
src/pipeIfc.sv
src/instrDecode.sv
src/regFile.sv
src/aluExecute.sv
src/cpuCore.sv
verif/cpuCore_assertions.sv
verif/cpuCoreTb.sv

/* src/aluExecute.sv */
// 8-bit ALU; set-on-less-than is unsigned against the full 16-bit second operand
`timescale 1ns/1ps

module aluExecute (
    input logic clk,
    input logic rst,
    decodedOpIf.consumer op,
    regReadIf.requester rd,
    output logic wbValid,
    output cpuPkg::regAddr_t wbAddr,
    output cpuPkg::data_t wbData
);

    cpuPkg::data_t opA;
    cpuPkg::imm_t opB;
    cpuPkg::data_t result;

    // operand fetch straight from the register file
    assign rd.addrA = op.srcA;
    assign rd.addrB = op.srcB;

    assign opA = rd.dataA;

    // register B is zero extended to the immediate width
    assign opB = op.useImm ? op.imm : {{(cpuPkg::immWidth - cpuPkg::dataWidth){1'b0}}, rd.dataB};

    always_comb begin
        result = '0;
        case (op.aluOp)
            cpuPkg::aluAdd: begin
                result = opA + opB[cpuPkg::dataWidth-1:0];
            end
            cpuPkg::aluSub: begin
                result = opA - opB[cpuPkg::dataWidth-1:0];
            end
            cpuPkg::aluAnd: begin
                result = opA & opB[cpuPkg::dataWidth-1:0];
            end
            cpuPkg::aluOr: begin
                result = opA | opB[cpuPkg::dataWidth-1:0];
            end
            cpuPkg::aluXor: begin
                result = opA ^ opB[cpuPkg::dataWidth-1:0];
            end
            // shift amounts of 8 or more give zero
            cpuPkg::aluSll: begin
                result = opA << op.shamt;
            end
            cpuPkg::aluSrl: begin
                result = opA >> op.shamt;
            end
            cpuPkg::aluSlt: begin
                // any immediate above 255 is always greater
                result = (cpuPkg::imm_t'(opA) < opB) ? cpuPkg::data_t'(1) : '0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= op.valid;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= op.dest;
        wbData <= result;
    end

endmodule

/* src/cpuCore.sv */
// fixed 2-cycle latency from instr to wbValid; no stall, no forwarding, no back-pressure
`timescale 1ns/1ps

module cpuCore (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input cpuPkg::instr_t instr,
    output logic wbValid,
    output cpuPkg::regAddr_t wbAddr,
    output cpuPkg::data_t wbData
);

    decodedOpIf decodedOp ();
    regReadIf regRead ();

    // stage 1, decode and register the operation
    instrDecode decodeStage (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .op(decodedOp.producer)
    );

    // written at the end of the writeback cycle
    regFile registers (
        .clk(clk),
        .rst(rst),
        .rd(regRead.responder),
        .wrEn(wbValid),
        .wrAddr(wbAddr),
        .wrData(wbData)
    );

    // stage 2, read operands, compute, hold the result
    aluExecute executeStage (
        .clk(clk),
        .rst(rst),
        .op(decodedOp.consumer),
        .rd(regRead.requester),
        .wbValid(wbValid),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

endmodule

/* src/cpuPkg.sv */
// widths are fixed by the 32-bit instruction format and the 8-bit datapath; do not resize
package cpuPkg;

    localparam int instrWidth = 32;
    localparam int dataWidth = 8;
    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;
    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int shamtWidth = 5;
    localparam int aluOpWidth = 4;

    // number of architectural registers
    localparam int regCount = 32;

    typedef logic [instrWidth-1:0] instr_t;
    typedef logic [dataWidth-1:0] data_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [immWidth-1:0] imm_t;
    typedef logic [opcodeWidth-1:0] opcode_t;
    typedef logic [functWidth-1:0] funct_t;
    typedef logic [shamtWidth-1:0] shamt_t;
    typedef logic [aluOpWidth-1:0] aluOp_t;

    // lsb of each field inside an instruction word
    localparam int opcodeLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int shamtLsb = 6;
    localparam int functLsb = 0;
    localparam int immLsb = 0;

    // major opcodes
    localparam opcode_t opRType = opcode_t'(0);
    localparam opcode_t opIFirst = opcode_t'(1);
    localparam opcode_t opILast = opcode_t'(8);

    // immediate opcodes 1..8 map one to one onto these codes
    localparam aluOp_t aluAdd = 4'd1;
    localparam aluOp_t aluSub = 4'd2;
    localparam aluOp_t aluAnd = 4'd3;
    localparam aluOp_t aluOr = 4'd4;
    localparam aluOp_t aluXor = 4'd5;
    localparam aluOp_t aluSll = 4'd6;
    localparam aluOp_t aluSrl = 4'd7;
    localparam aluOp_t aluSlt = 4'd8;

endpackage

/* src/instrDecode.sv */
// undefined opcodes, undefined funct values and writes to register 0 are dropped here
`timescale 1ns/1ps

module instrDecode (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input cpuPkg::instr_t instr,
    decodedOpIf.producer op
);

    cpuPkg::opcode_t opcode;
    cpuPkg::funct_t funct;
    cpuPkg::regAddr_t rs;
    cpuPkg::regAddr_t rt;
    cpuPkg::regAddr_t rdField;
    cpuPkg::shamt_t shamtField;
    cpuPkg::imm_t imm;

    logic legal;
    logic useImm;
    cpuPkg::aluOp_t aluOp;
    cpuPkg::regAddr_t dest;
    cpuPkg::shamt_t shamt;

    // field extraction
    assign opcode = instr[cpuPkg::opcodeLsb +: cpuPkg::opcodeWidth];
    assign funct = instr[cpuPkg::functLsb +: cpuPkg::functWidth];
    assign rs = instr[cpuPkg::rsLsb +: cpuPkg::regAddrWidth];
    assign rt = instr[cpuPkg::rtLsb +: cpuPkg::regAddrWidth];
    assign rdField = instr[cpuPkg::rdLsb +: cpuPkg::regAddrWidth];
    assign shamtField = instr[cpuPkg::shamtLsb +: cpuPkg::shamtWidth];
    assign imm = instr[cpuPkg::immLsb +: cpuPkg::immWidth];

    always_comb begin
        legal = 1'b0;
        useImm = 1'b0;
        aluOp = cpuPkg::aluAdd;
        dest = rdField;
        shamt = shamtField;
        if (opcode == cpuPkg::opRType) begin
            // operation taken from funct, only 1..8 defined
            legal = (funct >= cpuPkg::funct_t'(cpuPkg::aluAdd)) &&
                    (funct <= cpuPkg::funct_t'(cpuPkg::aluSlt));
            aluOp = cpuPkg::aluOp_t'(funct);
        end else if ((opcode >= cpuPkg::opIFirst) && (opcode <= cpuPkg::opILast)) begin
            legal = 1'b1;
            useImm = 1'b1;
            aluOp = cpuPkg::aluOp_t'(opcode);
            dest = rt;
            // immediate shifts use the low bits of the immediate
            shamt = imm[cpuPkg::shamtWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else begin
            // r0 is hardwired, so no write is ever issued for it
            op.valid <= instrValid && legal && (dest != '0);
        end
    end

    always_ff @(posedge clk) begin
        op.aluOp <= aluOp;
        op.srcA <= rs;
        op.srcB <= rt;
        op.imm <= imm;
        op.useImm <= useImm;
        op.shamt <= shamt;
        op.dest <= dest;
    end

endmodule

/* src/pipeIfc.sv */
// no handshake on either interface; decoded valid lasts one cycle and register reads are async
`timescale 1ns/1ps

// decode to execute, one live operation per valid cycle
interface decodedOpIf;
    logic valid;
    cpuPkg::aluOp_t aluOp;
    cpuPkg::regAddr_t srcA;
    cpuPkg::regAddr_t srcB;
    cpuPkg::imm_t imm;
    logic useImm;
    cpuPkg::shamt_t shamt;
    cpuPkg::regAddr_t dest;

    modport producer (
        output valid, aluOp, srcA, srcB, imm, useImm, shamt, dest
    );

    modport consumer (
        input valid, aluOp, srcA, srcB, imm, useImm, shamt, dest
    );
endinterface

// two read ports, data comes back in the same cycle
interface regReadIf;
    cpuPkg::regAddr_t addrA;
    cpuPkg::regAddr_t addrB;
    cpuPkg::data_t dataA;
    cpuPkg::data_t dataB;

    modport requester (
        output addrA, addrB,
        input dataA, dataB
    );

    modport responder (
        input addrA, addrB,
        output dataA, dataB
    );
endinterface

/* src/regFile.sv */
// all registers clear on reset; no bypass, a read sees the value before the same-edge write
`timescale 1ns/1ps

module regFile (
    input logic clk,
    input logic rst,
    regReadIf.responder rd,
    input logic wrEn,
    input cpuPkg::regAddr_t wrAddr,
    input cpuPkg::data_t wrData
);

    cpuPkg::data_t regs [cpuPkg::regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // both read ports are asynchronous
    assign rd.dataA = regs[rd.addrA];
    assign rd.dataB = regs[rd.addrB];

endmodule

/* verif/cpuCoreTb.sv */
// model has no forwarding so a read sees writes from two or more slots back; latency is 2 cycles
`timescale 1ns/1ps

module cpuCoreTb;

    typedef struct {
        logic doRst;
        logic valid;
        cpuPkg::instr_t word;
        logic expWb;
    } stimEntry_t;

    typedef struct {
        logic valid;
        cpuPkg::regAddr_t addr;
        cpuPkg::data_t data;
    } wbExpect_t;

    // operation numbers shared by funct and immediate opcodes
    localparam int opAdd = 1;
    localparam int opSub = 2;
    localparam int opAnd = 3;
    localparam int opOr = 4;
    localparam int opXor = 5;
    localparam int opSll = 6;
    localparam int opSrl = 7;
    localparam int opSlt = 8;
    localparam int drainLimit = 10;
    localparam int runLimitNs = 5000;

    logic clk;
    logic rst;
    logic instrValid;
    cpuPkg::instr_t instr;
    logic wbValid;
    cpuPkg::regAddr_t wbAddr;
    cpuPkg::data_t wbData;

    stimEntry_t stimTable[$];
    wbExpect_t expQ[$];
    cpuPkg::data_t modelRegs [32];
    integer seed;
    int errorCount;
    int checkCount;
    int drainCycles;

    cpuCore uut (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .wbValid(wbValid),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic cpuPkg::instr_t encodeR(input int funct, input int rs, input int rt,
                                               input int rd, input int shamt);
        cpuPkg::instr_t w;
        w = '0;
        w[25:21] = rs[4:0];
        w[20:16] = rt[4:0];
        w[15:11] = rd[4:0];
        w[10:6] = shamt[4:0];
        w[5:0] = funct[5:0];
        return w;
    endfunction

    function automatic cpuPkg::instr_t encodeI(input int opcode, input int rs, input int rt,
                                               input logic [15:0] imm);
        return {opcode[5:0], rs[4:0], rt[4:0], imm};
    endfunction

    function automatic cpuPkg::regAddr_t destOf(input cpuPkg::instr_t w);
        return (w[31:26] == 6'd0) ? w[15:11] : w[20:16];
    endfunction

    // reference ALU on the current model register state
    function automatic cpuPkg::data_t computeResult(input cpuPkg::instr_t w);
        int op;
        int shamt;
        logic [15:0] b;
        cpuPkg::data_t a;
        a = modelRegs[w[25:21]];
        if (w[31:26] == 6'd0) begin
            op = w[5:0];
            b = {8'h00, modelRegs[w[20:16]]};
            shamt = w[10:6];
        end else begin
            op = w[31:26];
            b = w[15:0];
            shamt = w[4:0];
        end
        case (op)
            opAdd: computeResult = a + b[7:0];
            opSub: computeResult = a - b[7:0];
            opAnd: computeResult = a & b[7:0];
            opOr: computeResult = a | b[7:0];
            opXor: computeResult = a ^ b[7:0];
            opSll: computeResult = a << shamt;
            opSrl: computeResult = a >> shamt;
            opSlt: computeResult = ({8'h00, a} < b) ? 8'd1 : 8'd0;
            default: computeResult = 8'd0;
        endcase
    endfunction

    function automatic logic pendingWriteback();
        foreach (expQ[i]) begin
            if (expQ[i].valid) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic addEntry(input logic doRst, input logic valid, input cpuPkg::instr_t word,
                            input logic expWb);
        stimEntry_t e;
        e.doRst = doRst;
        e.valid = valid;
        e.word = word;
        e.expWb = expWb;
        stimTable.push_back(e);
    endtask

    task automatic pushExpected(input logic valid, input cpuPkg::regAddr_t addr,
                                input cpuPkg::data_t data);
        wbExpect_t x;
        x.valid = valid;
        x.addr = addr;
        x.data = data;
        expQ.push_back(x);
    endtask

    task automatic checkWriteback(input wbExpect_t x);
        checkCount++;
        assert (wbValid === x.valid) else begin
            errorCount++;
            $display("Error at %0t: wbValid expected %0b, got %0b", $time, x.valid, wbValid);
        end
        if (x.valid && wbValid === 1'b1) begin
            assert (wbAddr === x.addr) else begin
                errorCount++;
                $display("Error at %0t: wbAddr expected %0d, got %0d", $time, x.addr, wbAddr);
            end
            assert (wbData === x.data) else begin
                errorCount++;
                $display("Error at %0t: wbData expected %h, got %h", $time, x.data, wbData);
            end
        end
    endtask

    // one clock slot checks the writeback due now, updates the model and drives the next input
    task automatic applySlot(input stimEntry_t e);
        wbExpect_t front;
        @(posedge clk);
        #1;
        if (expQ.size() == 2) begin
            front = expQ.pop_front();
            checkWriteback(front);
            if (front.valid) begin
                modelRegs[front.addr] = front.data;
            end
        end
        if (e.doRst) begin
            // in-flight results are lost and registers clear
            expQ.delete();
            foreach (modelRegs[i]) begin
                modelRegs[i] = '0;
            end
            pushExpected(1'b0, '0, '0);
        end
        if (e.valid && e.expWb && !e.doRst) begin
            pushExpected(1'b1, destOf(e.word), computeResult(e.word));
        end else begin
            pushExpected(1'b0, '0, '0);
        end
        rst = e.doRst;
        instrValid = e.valid;
        instr = e.word;
    endtask

    task automatic buildTable;
        logic [15:0] r2Imm;
        logic [15:0] andImm;
        logic [15:0] xorImm;
        r2Imm = $random(seed);
        r2Imm[15:8] = 8'h00;
        andImm = $random(seed);
        xorImm = $random(seed);
        // load source registers
        addEntry(0, 1, encodeI(opAdd, 0, 1, 16'h005c), 1);
        addEntry(0, 1, encodeI(opAdd, 0, 2, r2Imm), 1);
        addEntry(0, 0, '0, 0);
        addEntry(0, 1, encodeR(opAdd, 1, 2, 3, 0), 1);
        addEntry(0, 1, encodeR(opSub, 1, 2, 4, 0), 1);
        addEntry(0, 1, encodeR(opAnd, 1, 2, 5, 0), 1);
        addEntry(0, 1, encodeR(opOr, 1, 2, 6, 0), 1);
        addEntry(0, 1, encodeR(opXor, 1, 2, 7, 0), 1);
        addEntry(0, 1, encodeR(opSll, 1, 0, 8, 3), 1);
        addEntry(0, 1, encodeR(opSrl, 1, 0, 9, 2), 1);
        addEntry(0, 1, encodeR(opSlt, 1, 2, 10, 0), 1);
        addEntry(0, 1, encodeR(opSlt, 2, 1, 11, 0), 1);
        // immediate forms
        addEntry(0, 1, encodeI(opSub, 1, 12, 16'h0031), 1);
        addEntry(0, 1, encodeI(opAnd, 1, 13, andImm), 1);
        addEntry(0, 1, encodeI(opOr, 1, 14, 16'h0a03), 1);
        addEntry(0, 1, encodeI(opXor, 2, 15, xorImm), 1);
        addEntry(0, 1, encodeI(opSll, 2, 16, 16'h0025), 1);
        addEntry(0, 1, encodeI(opSrl, 2, 17, 16'h0001), 1);
        addEntry(0, 1, encodeI(opSlt, 1, 18, 16'h0123), 1);
        addEntry(0, 1, encodeI(opSlt, 1, 19, 16'h0010), 1);
        addEntry(0, 1, encodeI(opSll, 1, 29, 16'h000a), 1);
        // writer then readers one, two and three slots behind
        addEntry(0, 1, encodeI(opAdd, 0, 20, 16'h0007), 1);
        addEntry(0, 1, encodeI(opAdd, 20, 21, 16'h0001), 1);
        addEntry(0, 1, encodeI(opAdd, 20, 22, 16'h0001), 1);
        addEntry(0, 1, encodeR(opAdd, 20, 20, 23, 0), 1);
        // dropped ops with r0 target, undefined opcodes and funct values
        addEntry(0, 1, encodeI(opAdd, 1, 0, 16'h0005), 0);
        addEntry(0, 1, encodeI(9, 1, 24, 16'h0005), 0);
        addEntry(0, 1, encodeI(63, 1, 24, 16'h0005), 0);
        addEntry(0, 1, encodeR(0, 1, 2, 24, 0), 0);
        addEntry(0, 1, encodeR(9, 1, 2, 24, 0), 0);
        addEntry(0, 1, encodeR(opAdd, 1, 2, 0, 0), 0);
        addEntry(0, 0, '0, 0);
        addEntry(0, 1, encodeI(opAdd, 0, 24, 16'h0011), 1);
        addEntry(0, 1, encodeR(opSub, 1, 0, 25, 0), 1);
        // mid-run reset with results still in flight
        addEntry(1, 0, '0, 0);
        addEntry(1, 0, '0, 0);
        addEntry(1, 0, '0, 0);
        addEntry(0, 1, encodeR(opAdd, 1, 2, 26, 0), 1);
        addEntry(0, 1, encodeR(opOr, 7, 3, 27, 0), 1);
        addEntry(0, 1, encodeI(opSlt, 5, 28, 16'h0001), 1);
    endtask

    initial begin
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        seed = 32'h856a;
        errorCount = 0;
        checkCount = 0;
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        buildTable();
        // slots before release carry no writeback
        pushExpected(1'b0, '0, '0);
        pushExpected(1'b0, '0, '0);
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        foreach (stimTable[i]) begin
            applySlot(stimTable[i]);
        end
        drainCycles = 0;
        while (pendingWriteback() && drainCycles < drainLimit) begin
            applySlot('{1'b0, 1'b0, '0, 1'b0});
            drainCycles++;
        end
        if (pendingWriteback()) begin
            errorCount++;
            $display("timeout: expected writebacks still pending after %0d idle cycles",
                     drainLimit);
        end
        $display("writeback checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // guard against a stuck run
    initial begin
        #(runLimitNs);
        $display("timeout: simulation did not finish within %0d ns", runLimitNs);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* verif/cpuCore_assertions.sv */
// bound into cpuCore and reads its internal decoded valid; only the reset check runs while rst is high
`timescale 1ns/1ps

module cpuCoreAssertions (
    input logic clk,
    input logic rst,
    input logic opValid,
    input logic wbValid,
    input cpuPkg::regAddr_t wbAddr
);

    // register 0 is never a writeback target
    wbAddrNotZero: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> (wbAddr != '0))
        else $error("writeback pulse addressed register 0");

    // each decoded operation gives one writeback a cycle later
    wbFollowsOp: assert property (@(posedge clk) disable iff (rst)
        opValid |=> wbValid)
        else $error("decoded operation produced no writeback pulse");

    wbOnlyAfterOp: assert property (@(posedge clk) disable iff (rst)
        !opValid |=> !wbValid)
        else $error("writeback pulse without a decoded operation");

    wbLowAfterReset: assert property (@(posedge clk)
        rst |=> !wbValid)
        else $error("writeback pulse in the cycle after reset");

endmodule

bind cpuCore cpuCoreAssertions wbChecks (
    .clk(clk),
    .rst(rst),
    .opValid(decodedOp.valid),
    .wbValid(wbValid),
    .wbAddr(wbAddr)
);
